// File: Bender.yml
package:
  name: vid_out

sources:
  - rtl/vid_pkg.sv
  - rtl/vid_rst_hk.sv
  - rtl/vid_cfg_wb.sv
  - rtl/vid_capture.sv
  - rtl/vid_csc.sv
  - rtl/vid_blank.sv
  - rtl/vid_top.sv
  - target: test
    files:
      - verification/tb_vid_top.sv

// File: filelist.f
rtl/vid_pkg.sv
rtl/vid_rst_hk.sv
rtl/vid_cfg_wb.sv
rtl/vid_capture.sv
rtl/vid_csc.sv
rtl/vid_blank.sv
rtl/vid_top.sv
verification/tb_vid_top.sv

// File: rtl/vid_blank.sv
/*
  Output stage: blank level outside active video,
  syncs passed through, all outputs registered
*/
module vid_blank (
  input  logic                        VCLK_75M,
  input  logic                        vrst_n,
  input  logic [vid_pkg::COLOR_W-1:0] csc_r,
  input  logic [vid_pkg::COLOR_W-1:0] csc_g,
  input  logic [vid_pkg::COLOR_W-1:0] csc_b,
  input  logic                        csc_hs,
  input  logic                        csc_vs,
  input  logic                        csc_de,
  input  logic                        csc_ypbpr,
  output logic [vid_pkg::COLOR_W-1:0] vid_r,
  output logic [vid_pkg::COLOR_W-1:0] vid_g,
  output logic [vid_pkg::COLOR_W-1:0] vid_b,
  output logic                        vid_hs,
  output logic                        vid_vs,
  output logic                        vid_de
);

  import vid_pkg::*;

  // Chroma lanes blank at mid scale in YPbPr, at zero in RGB
  logic [COLOR_W-1:0] blank_chroma;

  assign blank_chroma = csc_ypbpr ? CHROMA_OFS : '0;

  always_ff @(posedge VCLK_75M) begin
    if (!vrst_n) begin
      {vid_r, vid_g, vid_b} <= '0;
      vid_hs <= 1'b1;
      vid_vs <= 1'b1;
      vid_de <= 1'b0;
    end else begin
      vid_r  <= csc_de ? csc_r : blank_chroma;
      // Luma or green blanks to zero in both modes
      vid_g  <= csc_de ? csc_g : '0;
      vid_b  <= csc_de ? csc_b : blank_chroma;
      vid_hs <= csc_hs;
      vid_vs <= csc_vs;
      vid_de <= csc_de;
    end
  end

endmodule

// File: rtl/vid_capture.sv
/*
  Capture stage: registers one N64 sample per clock with its syncs
  and the output mode, expands 7-bit colour to 8 bits
*/
module vid_capture (
  input  logic                           VCLK_75M,
  input  logic                           vrst_n,
  input  logic [vid_pkg::COLOR_IN_W-1:0] pix_r,
  input  logic [vid_pkg::COLOR_IN_W-1:0] pix_g,
  input  logic [vid_pkg::COLOR_IN_W-1:0] pix_b,
  input  logic                           pix_hs,
  input  logic                           pix_vs,
  input  logic                           pix_de,
  input  logic                           ypbpr_en,
  output logic [vid_pkg::COLOR_W-1:0]    cap_r,
  output logic [vid_pkg::COLOR_W-1:0]    cap_g,
  output logic [vid_pkg::COLOR_W-1:0]    cap_b,
  output logic                           cap_hs,
  output logic                           cap_vs,
  output logic                           cap_de,
  output logic                           cap_ypbpr
);

  import vid_pkg::*;

  // Reset levels: black, syncs inactive high, no active video
  always_ff @(posedge VCLK_75M) begin
    if (!vrst_n) begin
      cap_r     <= '0;
      cap_g     <= '0;
      cap_b     <= '0;
      cap_hs    <= 1'b1;
      cap_vs    <= 1'b1;
      cap_de    <= 1'b0;
      cap_ypbpr <= 1'b0;
    end else begin
      // MSB appended as new LSB so full scale maps to 255
      cap_r     <= {pix_r, pix_r[COLOR_IN_W-1]};
      cap_g     <= {pix_g, pix_g[COLOR_IN_W-1]};
      cap_b     <= {pix_b, pix_b[COLOR_IN_W-1]};
      cap_hs    <= pix_hs;
      cap_vs    <= pix_vs;
      cap_de    <= pix_de;
      // Mode travels with the pixel
      cap_ypbpr <= ypbpr_en;
    end
  end

endmodule

// File: rtl/vid_cfg_wb.sv
/*
  Wishbone classic register block:
  CTRL register with use-PLL and YPbPr enable,
  STATUS readback of PLL lock and pipeline reset
*/
module vid_cfg_wb (
  input  logic                         VCLK_75M,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [vid_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [vid_pkg::WB_DAT_W-1:0] wb_dat_w,
  output logic [vid_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                         wb_ack,
  input  logic                         pll_locked,
  input  logic                         vrst_n,
  output logic                         use_vpll,
  output logic                         ypbpr_en
);

  import vid_pkg::*;

  logic                wb_access;
  logic [WB_DAT_W-1:0] rd_data;

  // New access, the ack of the last one has already gone by
  assign wb_access = wb_cyc & wb_stb & ~wb_ack;

  ////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      REG_CTRL: begin
        rd_data[CTRL_USE_VPLL] = use_vpll;
        rd_data[CTRL_YPBPR]    = ypbpr_en;
      end
      REG_STATUS: begin
        rd_data[STAT_LOCKED] = pll_locked;
        rd_data[STAT_VRST_N] = vrst_n;
      end
      // Unused addresses read as zero
      default: rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Ack, read data and CTRL
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_75M) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      use_vpll <= 1'b0;
      ypbpr_en <= 1'b0;
    end else begin
      // Single ack cycle, one cycle after the request
      wb_ack <= wb_access;
      if (wb_access) begin
        wb_dat_r <= rd_data;
      end
      // Only CTRL is writable; STATUS and holes drop the data
      if (wb_access && wb_we && (wb_adr == REG_CTRL)) begin
        use_vpll <= wb_dat_w[CTRL_USE_VPLL];
        ypbpr_en <= wb_dat_w[CTRL_YPBPR];
      end
    end
  end

endmodule

// File: rtl/vid_csc.sv
/*
  Colour space stage: two-cycle RGB to YPbPr conversion with clipping,
  RGB passed through the same two registers when conversion is off
*/
module vid_csc (
  input  logic                        VCLK_75M,
  input  logic                        vrst_n,
  input  logic [vid_pkg::COLOR_W-1:0] cap_r,
  input  logic [vid_pkg::COLOR_W-1:0] cap_g,
  input  logic [vid_pkg::COLOR_W-1:0] cap_b,
  input  logic                        cap_hs,
  input  logic                        cap_vs,
  input  logic                        cap_de,
  input  logic                        cap_ypbpr,
  output logic [vid_pkg::COLOR_W-1:0] csc_r,
  output logic [vid_pkg::COLOR_W-1:0] csc_g,
  output logic [vid_pkg::COLOR_W-1:0] csc_b,
  output logic                        csc_hs,
  output logic                        csc_vs,
  output logic                        csc_de,
  output logic                        csc_ypbpr
);

  import vid_pkg::*;

  // Products indexed 0 = R, 1 = G, 2 = B
  logic signed [CSC_W-1:0] prod_y  [3];
  logic signed [CSC_W-1:0] prod_pb [3];
  logic signed [CSC_W-1:0] prod_pr [3];
  // Stage 1 side band and bypass colour
  logic [COLOR_W-1:0]      byp_r, byp_g, byp_b;
  logic                    s1_hs, s1_vs, s1_de, s1_ypbpr;
  // Stage 2 scaled levels before clipping
  logic signed [CSC_W-1:0] y_lvl, pb_lvl, pr_lvl;

  // Saturate a signed level into 0..255
  function automatic logic [COLOR_W-1:0] clip_color(input logic signed [CSC_W-1:0] lvl);
    if (lvl < 0) begin
      return '0;
    end
    if (lvl > 255) begin
      return '1;
    end
    return lvl[COLOR_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Stage 1: nine weighted products
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_75M) begin
    if (!vrst_n) begin
      for (int i = 0; i < 3; i++) begin
        prod_y[i]  <= '0;
        prod_pb[i] <= '0;
        prod_pr[i] <= '0;
      end
      {byp_r, byp_g, byp_b} <= '0;
      {s1_hs, s1_vs, s1_de, s1_ypbpr} <= 4'b1100;
    end else begin
      // Zero-extended colour times signed weight
      prod_y[0]  <= $signed({1'b0, cap_r}) * COEF_Y_R;
      prod_y[1]  <= $signed({1'b0, cap_g}) * COEF_Y_G;
      prod_y[2]  <= $signed({1'b0, cap_b}) * COEF_Y_B;
      prod_pb[0] <= $signed({1'b0, cap_r}) * COEF_PB_R;
      prod_pb[1] <= $signed({1'b0, cap_g}) * COEF_PB_G;
      prod_pb[2] <= $signed({1'b0, cap_b}) * COEF_PB_B;
      prod_pr[0] <= $signed({1'b0, cap_r}) * COEF_PR_R;
      prod_pr[1] <= $signed({1'b0, cap_g}) * COEF_PR_G;
      prod_pr[2] <= $signed({1'b0, cap_b}) * COEF_PR_B;
      {byp_r, byp_g, byp_b} <= {cap_r, cap_g, cap_b};
      {s1_hs, s1_vs, s1_de, s1_ypbpr} <= {cap_hs, cap_vs, cap_de, cap_ypbpr};
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stage 2: sum, scale by 1/256, chroma offset, clip
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    y_lvl  = (prod_y[0] + prod_y[1] + prod_y[2]) >>> 8;
    pb_lvl = ((prod_pb[0] + prod_pb[1] + prod_pb[2]) >>> 8) + $signed({1'b0, CHROMA_OFS});
    pr_lvl = ((prod_pr[0] + prod_pr[1] + prod_pr[2]) >>> 8) + $signed({1'b0, CHROMA_OFS});
  end

  always_ff @(posedge VCLK_75M) begin
    if (!vrst_n) begin
      {csc_r, csc_g, csc_b} <= '0;
      {csc_hs, csc_vs, csc_de, csc_ypbpr} <= 4'b1100;
    end else begin
      // YPbPr order on the RGB lanes is Pr, Y, Pb
      csc_r <= s1_ypbpr ? clip_color(pr_lvl) : byp_r;
      csc_g <= s1_ypbpr ? clip_color(y_lvl) : byp_g;
      csc_b <= s1_ypbpr ? clip_color(pb_lvl) : byp_b;
      {csc_hs, csc_vs, csc_de, csc_ypbpr} <= {s1_hs, s1_vs, s1_de, s1_ypbpr};
    end
  end

endmodule

// File: rtl/vid_pkg.sv
/*
  Shared definitions of the 75 MHz video output path:
  channel widths, Wishbone register map and bit positions,
  reset hold length, RGB to YPbPr coefficients and chroma offset
*/
package vid_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////

  // N64 colour channel and expanded DAC channel
  localparam int COLOR_IN_W = 7;
  localparam int COLOR_W    = 8;

  // Wishbone word address and data
  localparam int WB_ADR_W = 2;
  localparam int WB_DAT_W = 8;

  ////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////

  localparam logic [WB_ADR_W-1:0] REG_CTRL   = 2'd0;
  localparam logic [WB_ADR_W-1:0] REG_STATUS = 2'd1;

  // CTRL bits
  localparam int CTRL_USE_VPLL = 0;
  localparam int CTRL_YPBPR    = 1;

  // STATUS bits, read only
  localparam int STAT_LOCKED = 0;
  localparam int STAT_VRST_N = 1;

  // Pipeline reset hold after a use-PLL change
  localparam int HOLD_CYCLES = 16;
  localparam int HOLD_W      = 4;

  ////////////////////////////////////////////////////////////////////
  // Colour conversion, weights in 1/256 units
  ////////////////////////////////////////////////////////////////////

  // Coefficient and accumulator widths of the converter
  localparam int COEF_W = 9;
  localparam int CSC_W  = 18;

  localparam logic signed [COEF_W-1:0] COEF_Y_R  = 9'sd77;
  localparam logic signed [COEF_W-1:0] COEF_Y_G  = 9'sd150;
  localparam logic signed [COEF_W-1:0] COEF_Y_B  = 9'sd29;
  localparam logic signed [COEF_W-1:0] COEF_PB_R = -9'sd43;
  localparam logic signed [COEF_W-1:0] COEF_PB_G = -9'sd85;
  localparam logic signed [COEF_W-1:0] COEF_PB_B = 9'sd128;
  localparam logic signed [COEF_W-1:0] COEF_PR_R = 9'sd128;
  localparam logic signed [COEF_W-1:0] COEF_PR_G = -9'sd107;
  localparam logic signed [COEF_W-1:0] COEF_PR_B = -9'sd21;

  // Chroma zero level, also the Pb/Pr blank level
  localparam logic [COLOR_W-1:0] CHROMA_OFS = 8'd128;

endpackage

// File: rtl/vid_rst_hk.sv
/*
  Pipeline reset housekeeping for the 75 MHz video domain:
  use-PLL delay line, hold countdown on each mode edge
  and the registered pipeline reset
*/
module vid_rst_hk (
  input  logic VCLK_75M,
  input  logic rst_n,
  input  logic pll_locked,
  input  logic use_vpll,
  output logic vrst_n
);

  import vid_pkg::*;

  // Mode bit history, [2] is the oldest
  logic [2:0]        use_vpll_dly;
  logic [HOLD_W-1:0] hold_cnt;
  logic              mode_edge;
  logic              release_ok;

  // Any change of the mode seen at the end of the delay line
  assign mode_edge = use_vpll_dly[2] ^ use_vpll_dly[1];

  // All release conditions met in this cycle
  assign release_ok = pll_locked & use_vpll_dly[2] & ~|hold_cnt;

  ////////////////////////////////////////////////////////////////////
  // Delay line and hold countdown
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_75M) begin
    if (!rst_n) begin
      use_vpll_dly <= '0;
      hold_cnt     <= '0;
    end else begin
      use_vpll_dly <= {use_vpll_dly[1:0], use_vpll};
      // Reload wins over the countdown
      if (mode_edge) begin
        hold_cnt <= HOLD_W'(HOLD_CYCLES - 1);
      end else if (|hold_cnt) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////

  // Held low on system reset, lost lock, PLL unused or running hold
  always_ff @(posedge VCLK_75M) begin
    if (!rst_n) begin
      vrst_n <= 1'b0;
    end else begin
      vrst_n <= release_ok;
    end
  end

endmodule

// File: rtl/vid_top.sv
/*
  Top level of the 75 MHz video output path:
  register block, reset housekeeping and the three pipeline stages
*/
module vid_top (
  input  logic                           VCLK_75M,
  input  logic                           rst_n,
  // Wishbone classic slave
  input  logic                           wb_cyc,
  input  logic                           wb_stb,
  input  logic                           wb_we,
  input  logic [vid_pkg::WB_ADR_W-1:0]   wb_adr,
  input  logic [vid_pkg::WB_DAT_W-1:0]   wb_dat_w,
  output logic [vid_pkg::WB_DAT_W-1:0]   wb_dat_r,
  output logic                           wb_ack,
  // N64 video, syncs active low
  input  logic [vid_pkg::COLOR_IN_W-1:0] pix_r,
  input  logic [vid_pkg::COLOR_IN_W-1:0] pix_g,
  input  logic [vid_pkg::COLOR_IN_W-1:0] pix_b,
  input  logic                           pix_hs,
  input  logic                           pix_vs,
  input  logic                           pix_de,
  input  logic                           pll_locked,
  // DAC video, Pr/Y/Pb on r/g/b in YPbPr mode
  output logic [vid_pkg::COLOR_W-1:0]    vid_r,
  output logic [vid_pkg::COLOR_W-1:0]    vid_g,
  output logic [vid_pkg::COLOR_W-1:0]    vid_b,
  output logic                           vid_hs,
  output logic                           vid_vs,
  output logic                           vid_de
);

  import vid_pkg::*;

  logic               use_vpll, ypbpr_en, vrst_n;
  logic [COLOR_W-1:0] cap_r, cap_g, cap_b;
  logic               cap_hs, cap_vs, cap_de, cap_ypbpr;
  logic [COLOR_W-1:0] csc_r, csc_g, csc_b;
  logic               csc_hs, csc_vs, csc_de, csc_ypbpr;

  ////////////////////////////////////////////////////////////////////
  // Control and reset
  ////////////////////////////////////////////////////////////////////

  vid_cfg_wb u_cfg_wb (
    .VCLK_75M, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_dat_r, .wb_ack, .pll_locked, .vrst_n, .use_vpll, .ypbpr_en
  );

  vid_rst_hk u_rst_hk (
    .VCLK_75M, .rst_n, .pll_locked, .use_vpll, .vrst_n
  );

  ////////////////////////////////////////////////////////////////////
  // Pixel pipeline, 4 cycles end to end
  ////////////////////////////////////////////////////////////////////

  vid_capture u_capture (
    .VCLK_75M, .vrst_n, .pix_r, .pix_g, .pix_b, .pix_hs, .pix_vs, .pix_de,
    .ypbpr_en, .cap_r, .cap_g, .cap_b, .cap_hs, .cap_vs, .cap_de, .cap_ypbpr
  );

  vid_csc u_csc (
    .VCLK_75M, .vrst_n, .cap_r, .cap_g, .cap_b, .cap_hs, .cap_vs, .cap_de,
    .cap_ypbpr, .csc_r, .csc_g, .csc_b, .csc_hs, .csc_vs, .csc_de, .csc_ypbpr
  );

  vid_blank u_blank (
    .VCLK_75M, .vrst_n, .csc_r, .csc_g, .csc_b, .csc_hs, .csc_vs, .csc_de,
    .csc_ypbpr, .vid_r, .vid_g, .vid_b, .vid_hs, .vid_vs, .vid_de
  );

endmodule

// File: verification/tb_vid_top.sv
/*
  Testbench of the 75 MHz video output path with clock and reset,
  Wishbone register tasks, random pixel stream, queue reference model,
  concurrent output checks and a watchdog
*/
module tb_vid_top;

  import vid_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int RST_CYCLES    = 3;
  localparam int STREAM_CYCLES = 200;
  localparam int SHORT_CYCLES  = 50;
  // Input to output latency
  localparam int PIPE_LAT  = 4;
  // Cycles after a control change until vrst_n is known high or low
  localparam int SETTLE_HI = 22;
  localparam int SETTLE_LO = 6;
  // vrst_n release bound plus the pipeline
  localparam int RISE_MAX  = 20 + PIPE_LAT;
  localparam int RUN_CYCLES = RST_CYCLES + 2 * STREAM_CYCLES + 6 * SHORT_CYCLES;
  localparam int MARGIN     = 200;

  logic                  VCLK_75M;
  logic                  rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [WB_ADR_W-1:0]   wb_adr;
  logic [WB_DAT_W-1:0]   wb_dat_w;
  logic [WB_DAT_W-1:0]   wb_dat_r;
  logic                  wb_ack;
  logic [COLOR_IN_W-1:0] pix_r, pix_g, pix_b;
  logic                  pix_hs, pix_vs, pix_de;
  logic                  pll_locked;
  logic [COLOR_W-1:0]    vid_r, vid_g, vid_b;
  logic                  vid_hs, vid_vs, vid_de;

  // One input sample with its mode and the known vrst_n state
  typedef struct packed {
    logic [COLOR_IN_W-1:0] r;
    logic [COLOR_IN_W-1:0] g;
    logic [COLOR_IN_W-1:0] b;
    logic                  hs;
    logic                  vs;
    logic                  de;
    logic                  ypbpr;
    logic                  on;
    logic                  off;
  } pix_ent_t;

  pix_ent_t           pipe_q[$];
  integer             seed = 33;
  int                 err_cnt = 0;
  int                 cmp_cnt = 0;
  int                 hi_cnt = 0;
  int                 lo_cnt = 0;
  // CTRL as last written and valid from the ack edge
  logic               use_cur = 1'b0;
  logic               ypbpr_cur = 1'b0;
  // de pattern 0 holds low, 1 holds high and any other is random
  int                 de_mode = 2;
  logic               exp_chk = 1'b0;
  logic [COLOR_W-1:0] exp_r, exp_g, exp_b;
  logic               exp_hs, exp_vs, exp_de;

  vid_top DUT (.*);

  initial begin
    VCLK_75M = 1'b0;
    forever #(CLK_PERIOD / 2) VCLK_75M = ~VCLK_75M;
  end

  initial begin
    #(CLK_PERIOD * (RUN_CYCLES + MARGIN));
    $display("Watchdog expired after %0d cycles", RUN_CYCLES + MARGIN);
    $display("Some tests failed");
    $finish;
  end

  task automatic flag_mismatch(input string sig, input logic [COLOR_W-1:0] exp_v,
                               input logic [COLOR_W-1:0] got_v);
    err_cnt++;
    $display("ERR %0t %s expected %0h actual %0h", $time, sig, exp_v, got_v);
  endtask

  task automatic note_failure(input string what);
    err_cnt++;
    $display("%0t: %s", $time, what);
  endtask

  function automatic logic [COLOR_W-1:0] clip8(input int v);
    return (v < 0) ? 8'd0 : (v > 255) ? 8'd255 : COLOR_W'(v);
  endfunction

  // Output lanes for one input sample including the blank level
  function automatic void predict(input pix_ent_t p, output logic [COLOR_W-1:0] r8,
                                  output logic [COLOR_W-1:0] g8, output logic [COLOR_W-1:0] b8);
    int r;
    int g;
    int b;
    r = {p.r, p.r[COLOR_IN_W-1]};
    g = {p.g, p.g[COLOR_IN_W-1]};
    b = {p.b, p.b[COLOR_IN_W-1]};
    if (!p.de) begin
      r8 = p.ypbpr ? CHROMA_OFS : '0;
      g8 = '0;
      b8 = r8;
    end else if (p.ypbpr) begin
      // Lanes carry Pr, Y, Pb
      g8 = clip8((int'(COEF_Y_R) * r + int'(COEF_Y_G) * g + int'(COEF_Y_B) * b) >>> 8);
      b8 = clip8(((int'(COEF_PB_R) * r + int'(COEF_PB_G) * g + int'(COEF_PB_B) * b) >>> 8)
                 + int'(CHROMA_OFS));
      r8 = clip8(((int'(COEF_PR_R) * r + int'(COEF_PR_G) * g + int'(COEF_PR_B) * b) >>> 8)
                 + int'(CHROMA_OFS));
    end else begin
      r8 = COLOR_W'(r);
      g8 = COLOR_W'(g);
      b8 = COLOR_W'(b);
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge VCLK_75M) begin
    pix_r  = COLOR_IN_W'($random(seed));
    pix_g  = COLOR_IN_W'($random(seed));
    pix_b  = COLOR_IN_W'($random(seed));
    // Syncs mostly inactive high
    pix_hs = ($random(seed) % 16) != 0;
    pix_vs = ($random(seed) % 16) != 0;
    case (de_mode)
      0: pix_de = 1'b0;
      1: pix_de = 1'b1;
      default: pix_de = ($random(seed) % 4) != 0;
    endcase
  end

  // One Wishbone classic cycle started and ended just after a falling edge
  task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] wdat, output logic [WB_DAT_W-1:0] rdat);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    do begin
      @(negedge VCLK_75M);
      waited++;
    end while (!wb_ack && waited < 8);
    assert (wb_ack && waited == 1)
      else note_failure($sformatf("No ack one cycle after request to address %0d", adr));
    rdat = wb_dat_r;
    // CTRL write takes effect on the ack edge
    if (we && adr == REG_CTRL) begin
      use_cur   = wdat[CTRL_USE_VPLL];
      ypbpr_cur = wdat[CTRL_YPBPR];
    end
    // Master still requests on the edge that samples the ack
    @(negedge VCLK_75M);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
    logic [WB_DAT_W-1:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic check_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] exp_v,
                           input string name);
    logic [WB_DAT_W-1:0] got;
    bus_access(1'b0, adr, '0, got);
    assert (got == exp_v) else flag_mismatch(name, exp_v, got);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge VCLK_75M);
  endtask

  // Poll STATUS until the pipeline reset is released
  task automatic wait_release();
    logic [WB_DAT_W-1:0] st;
    int polls;
    polls = 0;
    do begin
      bus_access(1'b0, REG_STATUS, '0, st);
      polls++;
    end while (!st[STAT_VRST_N] && polls < 12);
    assert (st[STAT_VRST_N]) else note_failure("Pipeline reset never released in STATUS");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model with four pixels in flight
  //////////////////////////////////////////////////////////////////////

  always @(posedge VCLK_75M) begin
    pix_ent_t           ent;
    logic               any_off;
    logic               all_on;
    logic [COLOR_W-1:0] r8, g8, b8;
    // Time since the last change of reset, lock or use-PLL
    if (rst_n && use_cur && pll_locked) begin
      hi_cnt = hi_cnt + 1;
      lo_cnt = 0;
    end else begin
      lo_cnt = lo_cnt + 1;
      hi_cnt = 0;
    end
    ent = {pix_r, pix_g, pix_b, pix_hs, pix_vs, pix_de, ypbpr_cur,
           hi_cnt >= SETTLE_HI, lo_cnt >= SETTLE_LO};
    pipe_q.push_back(ent);
    if (pipe_q.size() > PIPE_LAT) begin
      void'(pipe_q.pop_front());
    end
    any_off = 1'b0;
    all_on  = (pipe_q.size() == PIPE_LAT);
    foreach (pipe_q[i]) begin
      any_off |= pipe_q[i].off;
      all_on  &= pipe_q[i].on;
    end
    // No compare while an unknown reset state is in flight
    exp_chk <= all_on || any_off;
    if (all_on || any_off) begin
      cmp_cnt++;
    end
    if (any_off || !all_on) begin
      {exp_r, exp_g, exp_b} <= '0;
      {exp_hs, exp_vs, exp_de} <= 3'b110;
    end else begin
      predict(pipe_q[0], r8, g8, b8);
      exp_r  <= r8;
      exp_g  <= g8;
      exp_b  <= b8;
      exp_hs <= pipe_q[0].hs;
      exp_vs <= pipe_q[0].vs;
      exp_de <= pipe_q[0].de;
    end
  end

  // Output checks
  a_vid_r: assert property (@(posedge VCLK_75M) exp_chk |-> vid_r == exp_r)
    else flag_mismatch("vid_r", $sampled(exp_r), $sampled(vid_r));
  a_vid_g: assert property (@(posedge VCLK_75M) exp_chk |-> vid_g == exp_g)
    else flag_mismatch("vid_g", $sampled(exp_g), $sampled(vid_g));
  a_vid_b: assert property (@(posedge VCLK_75M) exp_chk |-> vid_b == exp_b)
    else flag_mismatch("vid_b", $sampled(exp_b), $sampled(vid_b));
  a_vid_hs: assert property (@(posedge VCLK_75M) exp_chk |-> vid_hs == exp_hs)
    else flag_mismatch("vid_hs", $sampled(exp_hs), $sampled(vid_hs));
  a_vid_vs: assert property (@(posedge VCLK_75M) exp_chk |-> vid_vs == exp_vs)
    else flag_mismatch("vid_vs", $sampled(exp_vs), $sampled(vid_vs));
  a_vid_de: assert property (@(posedge VCLK_75M) exp_chk |-> vid_de == exp_de)
    else flag_mismatch("vid_de", $sampled(exp_de), $sampled(vid_de));
  // Ack lasts exactly one cycle
  a_ack_once: assert property (@(posedge VCLK_75M) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else note_failure("wb_ack stayed high for more than one cycle");

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int cnt;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    {pix_r, pix_g, pix_b} = '0;
    {pix_hs, pix_vs, pix_de} = 3'b110;
    pll_locked = 1'b1;
    repeat (RST_CYCLES) @(posedge VCLK_75M);
    @(negedge VCLK_75M);
    rst_n = 1'b1;
    wait_cycles(8);
    // Locked after reset but pipeline still held
    assert (!wb_ack && !vid_de) else note_failure("wb_ack or vid_de high after reset");
    check_reg(REG_CTRL, 8'h00, "CTRL");
    check_reg(REG_STATUS, 8'h01, "STATUS");
    // Register map with upper data bits dropped
    write_reg(REG_CTRL, 8'h02);
    check_reg(REG_CTRL, 8'h02, "CTRL");
    write_reg(REG_CTRL, 8'hFC);
    check_reg(REG_CTRL, 8'h00, "CTRL");
    write_reg(REG_STATUS, 8'hFF);
    write_reg(2'd2, 8'hFF);
    check_reg(REG_CTRL, 8'h00, "CTRL");
    check_reg(REG_STATUS, 8'h01, "STATUS");
    check_reg(2'd2, 8'h00, "ADR2");
    check_reg(2'd3, 8'h00, "ADR3");
    // RGB stream
    write_reg(REG_CTRL, 8'h01);
    check_reg(REG_CTRL, 8'h01, "CTRL");
    wait_release();
    check_reg(REG_STATUS, 8'h03, "STATUS");
    wait_cycles(STREAM_CYCLES);
    // YPbPr stream with the mode switch on a pixel boundary
    write_reg(REG_CTRL, 8'h03);
    check_reg(REG_CTRL, 8'h03, "CTRL");
    wait_cycles(STREAM_CYCLES);
    de_mode = 0;
    wait_cycles(SHORT_CYCLES / 2);
    de_mode = 1;
    wait_cycles(SHORT_CYCLES / 2);
    // Use-PLL toggle and hold time
    write_reg(REG_CTRL, 8'h02);
    cnt = 0;
    while (vid_de && cnt < 12) begin
      @(negedge VCLK_75M);
      cnt++;
    end
    assert (!vid_de) else note_failure("vid_de still high after use-PLL was cleared");
    write_reg(REG_CTRL, 8'h03);
    cnt = 1;
    while (!vid_de && cnt < RISE_MAX + 4) begin
      @(negedge VCLK_75M);
      cnt++;
    end
    assert (vid_de && cnt >= HOLD_CYCLES && cnt <= RISE_MAX)
      else note_failure($sformatf("vid_de returned %0d cycles after use-PLL set", cnt));
    de_mode = 2;
    wait_cycles(SHORT_CYCLES);
    // Lock loss clears the pipeline
    pll_locked = 1'b0;
    wait_cycles(6);
    assert (!vid_de) else note_failure("vid_de not cleared after PLL lock loss");
    check_reg(REG_STATUS, 8'h00, "STATUS");
    pll_locked = 1'b1;
    wait_release();
    wait_cycles(SHORT_CYCLES);
    $display("Compared %0d output samples, %0d errors", cmp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
